//--- hw/bch_pkg.sv
// BCH(15,5) erasure decoder shared constants, vector types, packet structs
// and GF(2^4) arithmetic helpers
package bch_pkg;

  // ---------------------------------------------------------------------------
  // code constants
  // ---------------------------------------------------------------------------
  localparam int cM       = 4;
  localparam int cN       = 15;
  localparam int cT       = 3;
  localparam int cT2      = 6;
  localparam int cIRRPOL  = 19;

  // berlekamp counters: iteration and step within iteration
  localparam int cCNT_W   = $clog2(cT + 1);
  localparam int cTCNT_W  = $clog2(cT2 + 1);

  // wishbone bus
  localparam int cWB_ADDR_W = 2;
  localparam int cWB_DATA_W = 32;

  // ---------------------------------------------------------------------------
  // types
  // ---------------------------------------------------------------------------
  typedef logic [cM-1:0]  data_t;
  // bit i holds coefficient of x^i
  typedef logic [cN-1:0]  word_t;
  typedef logic [1:0]     tag_t;
  typedef logic [2:0]     corr_cnt_t;

  // S1..S6 of one fill
  typedef data_t [cT2:1]  syndrome_set_t;
  // locator coefficients 0..t
  typedef data_t [cT:0]   loc_poly_t;

  typedef struct packed {
    syndrome_set_t  s_zero;
    syndrome_set_t  s_one;
    word_t          w_zero;
    word_t          w_one;
    tag_t           tag;
  } synd_pkt_t;

  typedef struct packed {
    loc_poly_t  l_zero;
    loc_poly_t  l_one;
    word_t      w_zero;
    word_t      w_one;
    tag_t       tag;
  } loc_pkt_t;

  typedef struct packed {
    word_t      word;
    tag_t       tag;
    logic       fail;
    corr_cnt_t  cnt;
  } dec_rslt_t;

  // ---------------------------------------------------------------------------
  // GF(2^4) helpers
  // ---------------------------------------------------------------------------
  // shift and add multiply, reduced by field polynomial
  function automatic data_t gf_mult(data_t a, data_t b);
    logic [cM:0]   aa;
    logic [cM-1:0] acc;
    aa  = {1'b0, a};
    acc = '0;
    for (int i = 0; i < cM; i++) begin
      if (b[i]) acc = acc ^ aa[cM-1:0];
      aa = aa << 1;
      if (aa[cM]) aa = aa ^ cIRRPOL[cM:0];
    end
    return acc;
  endfunction

  // alpha^p, exponent taken mod 15
  function automatic data_t gf_alpha_pow(int p);
    case (p % cN)
      0:  return 4'h1;
      1:  return 4'h2;
      2:  return 4'h4;
      3:  return 4'h8;
      4:  return 4'h3;
      5:  return 4'h6;
      6:  return 4'hC;
      7:  return 4'hB;
      8:  return 4'h5;
      9:  return 4'hA;
      10: return 4'h7;
      11: return 4'hE;
      12: return 4'hF;
      13: return 4'hD;
      default: return 4'h9;
    endcase
  endfunction

endpackage

//--- hw/bch_wb_regs.sv
// Wishbone classic slave with word, mask, tag and start registers
// plus latched result and status readback
`timescale 1ns/1ps

module bch_wb_regs
  import bch_pkg::*;
(
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [cWB_ADDR_W-1:0]   wb_adr,
  input  logic [cWB_DATA_W-1:0]   wb_dat_i,
  output logic [cWB_DATA_W-1:0]   wb_dat_o,
  output logic                    wb_ack,
  output logic                    start,
  output word_t                   rx_word,
  output word_t                   eras_mask,
  output tag_t                    tag,
  input  logic                    rslt_val,
  input  dec_rslt_t               rslt
);

  logic       busy;
  logic       done;
  dec_rslt_t  rslt_q;
  logic       access;
  logic       start_req;
  logic       go;

  // new cycle not yet acked
  assign access    = wb_cyc & wb_stb & ~wb_ack;
  assign start_req = wb_we & (wb_adr == 2'd1) & wb_dat_i[31];
  // start write waits while a block is in flight
  assign go        = access & ~(start_req & busy);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      busy   <= 1'b0;
      done   <= 1'b0;
      rslt_q <= '0;
    end else begin
      wb_ack <= go;
      start  <= go & start_req;
      if (go & start_req) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (rslt_val) begin
        busy   <= 1'b0;
        done   <= 1'b1;
        rslt_q <= rslt;
      end
    end
  end

  // write registers, payload only
  always_ff @(posedge iclk) begin
    if (go & wb_we) begin
      case (wb_adr)
        2'd0: rx_word <= wb_dat_i[cN-1:0];
        2'd1: begin
          eras_mask <= wb_dat_i[cN-1:0];
          tag       <= wb_dat_i[17:16];
        end
        default: ;
      endcase
    end
  end

  // read mux
  always_comb begin
    case (wb_adr)
      2'd0:    wb_dat_o = {17'd0, rx_word};
      2'd1:    wb_dat_o = {14'd0, tag, 1'b0, eras_mask};
      2'd2:    wb_dat_o = {25'd0, rslt_q.cnt, rslt_q.tag, rslt_q.fail, done};
      default: wb_dat_o = {17'd0, rslt_q.word};
    endcase
  end

endmodule

//--- hw/bch_eras_syndrome.sv
// syndrome unit, two erasure fills evaluated bit-serially by Horner rule
`timescale 1ns/1ps

module bch_eras_syndrome
  import bch_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       start,
  input  word_t      rx_word,
  input  word_t      eras_mask,
  input  tag_t       tag,
  output logic       synd_val,
  output synd_pkt_t  synd
);

  enum logic {cIDLE, cRUN} state;

  logic [3:0]  cnt;
  word_t       fill0;
  word_t       fill1;
  word_t       sh0;
  word_t       sh1;

  // erased positions forced low / high
  assign fill0 = rx_word & ~eras_mask;
  assign fill1 = rx_word | eras_mask;

  // ---------------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= cIDLE;
      cnt      <= '0;
      synd_val <= 1'b0;
    end else begin
      synd_val <= 1'b0;
      case (state)
        cIDLE: if (start) begin
          state <= cRUN;
          cnt   <= '0;
        end
        default: begin
          cnt <= cnt + 1'b1;
          // 14 more bits after the first one taken at start
          if (cnt == 4'd13) begin
            state    <= cIDLE;
            synd_val <= 1'b1;
          end
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // horner accumulators, high bit first
  // ---------------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (state == cIDLE && start) begin
      sh0         <= fill0 << 1;
      sh1         <= fill1 << 1;
      synd.w_zero <= fill0;
      synd.w_one  <= fill1;
      synd.tag    <= tag;
      // first step from a zero accumulator is just the top bit
      for (int j = 1; j <= cT2; j++) begin
        synd.s_zero[j] <= {3'd0, fill0[cN-1]};
        synd.s_one[j]  <= {3'd0, fill1[cN-1]};
      end
    end else if (state == cRUN) begin
      sh0 <= sh0 << 1;
      sh1 <= sh1 << 1;
      for (int j = 1; j <= cT2; j++) begin
        synd.s_zero[j] <= gf_mult(synd.s_zero[j], gf_alpha_pow(j)) ^ {3'd0, sh0[cN-1]};
        synd.s_one[j]  <= gf_mult(synd.s_one[j], gf_alpha_pow(j)) ^ {3'd0, sh1[cN-1]};
      end
    end
  end

endmodule

//--- hw/bch_eras_berlekamp_ribm_t_by_t.sv
// two-pass inversionless Berlekamp-Massey unit for binary BCH, t = 3
// one multiplier pair shared over every step of both passes
`timescale 1ns/1ps

module bch_eras_berlekamp_ribm_t_by_t
  import bch_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       synd_val,
  input  synd_pkt_t  synd,
  output logic       loc_val,
  output loc_pkt_t   loc
);

  enum logic [1:0] {cWAIT, cSTEP1, cRELOAD, cSTEP2} state;

  // iteration 0..t-1, t marks the closing cycle of a pass
  logic [cCNT_W-1:0]   cnt;
  // step inside one iteration, 0..t2
  logic [cTCNT_W-1:0]  tcnt;
  logic                stepping;
  logic                iter_end;
  logic                pass_end;

  syndrome_set_t  sy;
  syndrome_set_t  s1_lat;
  loc_poly_t      lam;
  loc_poly_t      lam_n;
  loc_poly_t      b;
  loc_poly_t      l0_hold;
  data_t          gam;
  data_t          delta;
  logic signed [3:0] kv;

  // per block context carried to the output packet
  word_t  w0_q;
  word_t  w1_q;
  tag_t   tag_q;

  data_t  m1a, m1b, m2a, m2b;
  data_t  p1, p2;

  assign stepping = (state == cSTEP1 || state == cSTEP2) && (cnt != cT[cCNT_W-1:0]);
  assign iter_end = (tcnt == cT2[cTCNT_W-1:0]);
  assign pass_end = (cnt == cT[cCNT_W-1:0]);

  // S(idx) of the running pass, zero outside 1..t2
  function automatic data_t s_at(syndrome_set_t s, int idx);
    if (idx < 1 || idx > cT2) return '0;
    return s[idx];
  endfunction

  // ---------------------------------------------------------------------------
  // FSM and counters
  // ---------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= cWAIT;
      cnt     <= '0;
      tcnt    <= '0;
      loc_val <= 1'b0;
    end else begin
      loc_val <= (state == cSTEP2) && stepping && iter_end && (cnt == cCNT_W'(cT - 1));
      case (state)
        cWAIT:   if (synd_val) state <= cSTEP1;
        cSTEP1:  if (pass_end) state <= cRELOAD;
        cRELOAD: state <= cSTEP2;
        default: if (pass_end) state <= cWAIT;
      endcase
      if (stepping) begin
        tcnt <= iter_end ? '0 : tcnt + 1'b1;
        if (iter_end) cnt <= cnt + 1'b1;
      end else begin
        tcnt <= '0;
        cnt  <= '0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // shared multiplier pair
  // steps 0,1 build delta, steps 2..5 update one coefficient each
  // ---------------------------------------------------------------------------
  always_comb begin
    int r;
    int i;
    r   = 2 * int'(cnt);
    i   = int'(tcnt) - 2;
    m1a = '0;
    m1b = '0;
    m2a = '0;
    m2b = '0;
    if (tcnt == 3'd0) begin
      m1a = lam[0];
      m1b = s_at(sy, r + 1);
      m2a = lam[1];
      m2b = s_at(sy, r);
    end else if (tcnt == 3'd1) begin
      m1a = lam[2];
      m1b = s_at(sy, r - 1);
      m2a = lam[3];
      m2b = s_at(sy, r - 2);
    end else if (i >= 0 && i <= cT) begin
      // gamma*lambda_i + delta*b_(i-1)
      m1a = gam;
      m1b = lam[i];
      m2a = delta;
      m2b = (i == 0) ? '0 : b[i-1];
    end
  end

  assign p1 = gf_mult(m1a, m1b);
  assign p2 = gf_mult(m2a, m2b);

  // ---------------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if ((state == cWAIT && synd_val) || state == cRELOAD) begin
      // lambda = b = gamma = 1, k = 0
      lam   <= loc_poly_t'(1);
      b     <= loc_poly_t'(1);
      gam   <= data_t'(1);
      kv    <= '0;
      delta <= '0;
    end else if (stepping) begin
      if (tcnt == 3'd0) begin
        delta <= p1 ^ p2;
      end else if (tcnt == 3'd1) begin
        delta <= delta ^ p1 ^ p2;
      end else if (!iter_end) begin
        lam_n[tcnt-2] <= p1 ^ p2;
      end else begin
        lam <= lam_n;
        // odd step folded in, so b moves by x or x^2
        if (delta != '0 && !kv[3]) begin
          b   <= {lam[cT-1:0], data_t'(0)};
          gam <= delta;
          kv  <= -kv;
        end else begin
          b  <= {b[cT-2:0], data_t'(0), data_t'(0)};
          kv <= kv + 4'sd2;
        end
      end
    end
    // per block context
    if (state == cWAIT && synd_val) begin
      sy     <= synd.s_zero;
      s1_lat <= synd.s_one;
      w0_q   <= synd.w_zero;
      w1_q   <= synd.w_one;
      tag_q  <= synd.tag;
    end
    if (state == cRELOAD) begin
      sy      <= s1_lat;
      l0_hold <= lam;
    end
  end

  // field order l_zero, l_one, w_zero, w_one, tag
  assign loc = {l0_hold, lam, w0_q, w1_q, tag_q};

endmodule

//--- hw/bch_eras_chien.sv
// Chien search over both locators, candidate choice and word correction
`timescale 1ns/1ps

module bch_eras_chien
  import bch_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       loc_val,
  input  loc_pkt_t   loc,
  output logic       rslt_val,
  output dec_rslt_t  rslt
);

  logic        run;
  logic [3:0]  pos;
  loc_poly_t   term  [2];
  word_t       cw    [2];
  word_t       base0;
  logic [3:0]  roots [2];
  logic [1:0]  deg   [2];
  tag_t        tag_q;
  logic        valid [2];
  logic        pick1;

  // highest nonzero coefficient
  function automatic logic [1:0] poly_deg(loc_poly_t p);
    logic [1:0] d;
    d = '0;
    for (int j = 1; j <= cT; j++) begin
      if (p[j] != '0) d = 2'(j);
    end
    return d;
  endfunction

  // ---------------------------------------------------------------------------
  // control, one position per cycle
  // ---------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      run      <= 1'b0;
      pos      <= '0;
      rslt_val <= 1'b0;
    end else begin
      rslt_val <= run && (pos == 4'(cN - 1));
      if (loc_val) begin
        run <= 1'b1;
        pos <= '0;
      end else if (run) begin
        pos <= pos + 1'b1;
        if (pos == 4'(cN - 1)) run <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // search datapath
  // ---------------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (loc_val) begin
      term[0]  <= loc.l_zero;
      term[1]  <= loc.l_one;
      cw[0]    <= loc.w_zero;
      cw[1]    <= loc.w_one;
      base0    <= loc.w_zero;
      deg[0]   <= poly_deg(loc.l_zero);
      deg[1]   <= poly_deg(loc.l_one);
      roots[0] <= '0;
      roots[1] <= '0;
      tag_q    <= loc.tag;
    end else if (run) begin
      for (int c = 0; c < 2; c++) begin
        // lambda(alpha^-pos) == 0 marks an error at pos
        if ((term[c][0] ^ term[c][1] ^ term[c][2] ^ term[c][3]) == '0) begin
          cw[c][pos] <= ~cw[c][pos];
          roots[c]   <= roots[c] + 1'b1;
        end
        // term j steps by alpha^-j
        for (int j = 0; j <= cT; j++) begin
          term[c][j] <= gf_mult(term[c][j], gf_alpha_pow(cN - j));
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // candidate choice, tie keeps zero fill
  // ---------------------------------------------------------------------------
  assign valid[0] = (roots[0] == {2'b00, deg[0]});
  assign valid[1] = (roots[1] == {2'b00, deg[1]});
  assign pick1    = valid[1] && (!valid[0] || roots[1] < roots[0]);

  always_comb begin
    rslt.tag = tag_q;
    if (pick1) begin
      rslt.word = cw[1];
      rslt.fail = 1'b0;
      rslt.cnt  = roots[1][2:0];
    end else if (valid[0]) begin
      rslt.word = cw[0];
      rslt.fail = 1'b0;
      rslt.cnt  = roots[0][2:0];
    end else begin
      // no valid candidate, pass zero-filled word
      rslt.word = base0;
      rslt.fail = 1'b1;
      rslt.cnt  = '0;
    end
  end

endmodule

//--- hw/bch_eras_dec_top.sv
// decoder top, bus slave followed by syndrome, Berlekamp and Chien stages
`timescale 1ns/1ps

module bch_eras_dec_top
  import bch_pkg::*;
(
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [cWB_ADDR_W-1:0]   wb_adr,
  input  logic [cWB_DATA_W-1:0]   wb_dat_i,
  output logic [cWB_DATA_W-1:0]   wb_dat_o,
  output logic                    wb_ack
);

  logic       start;
  word_t      rx_word;
  word_t      eras_mask;
  tag_t       tag;
  logic       synd_val;
  synd_pkt_t  synd;
  logic       loc_val;
  loc_pkt_t   loc;
  logic       rslt_val;
  dec_rslt_t  rslt;

  bch_wb_regs i_bch_wb_regs (
    .iclk      (iclk),
    .ireset    (ireset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .start     (start),
    .rx_word   (rx_word),
    .eras_mask (eras_mask),
    .tag       (tag),
    .rslt_val  (rslt_val),
    .rslt      (rslt)
  );

  bch_eras_syndrome i_bch_eras_syndrome (
    .iclk      (iclk),
    .ireset    (ireset),
    .start     (start),
    .rx_word   (rx_word),
    .eras_mask (eras_mask),
    .tag       (tag),
    .synd_val  (synd_val),
    .synd      (synd)
  );

  bch_eras_berlekamp_ribm_t_by_t i_bch_eras_berlekamp (
    .iclk      (iclk),
    .ireset    (ireset),
    .synd_val  (synd_val),
    .synd      (synd),
    .loc_val   (loc_val),
    .loc       (loc)
  );

  bch_eras_chien i_bch_eras_chien (
    .iclk      (iclk),
    .ireset    (ireset),
    .loc_val   (loc_val),
    .loc       (loc),
    .rslt_val  (rslt_val),
    .rslt      (rslt)
  );

endmodule

//--- dv/bch_eras_chk.sv
// concurrent assertions on the Wishbone bus and the stage handshakes,
// bound into the decoder top
`timescale 1ns/1ps

module bch_eras_chk (
  input logic iclk,
  input logic ireset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic synd_val,
  input logic loc_val,
  input logic rslt_val
);

  // block sits between syndrome and locator hand-off
  logic in_flight;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      in_flight <= 1'b0;
    end else if (synd_val) begin
      in_flight <= 1'b1;
    end else if (loc_val) begin
      in_flight <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // bus
  // --------------------------------------------------------------------------
  a_ack_in_cycle: assert property (@(posedge iclk) disable iff (ireset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack raised outside an active cycle");

  a_ack_single: assert property (@(posedge iclk) disable iff (ireset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one cycle");

  // --------------------------------------------------------------------------
  // stage valids, single-cycle pulses
  // --------------------------------------------------------------------------
  a_synd_pulse: assert property (@(posedge iclk) disable iff (ireset)
    synd_val |=> !synd_val)
    else $error("synd_val longer than one cycle");

  a_loc_pulse: assert property (@(posedge iclk) disable iff (ireset)
    loc_val |=> !loc_val)
    else $error("loc_val longer than one cycle");

  a_rslt_pulse: assert property (@(posedge iclk) disable iff (ireset)
    rslt_val |=> !rslt_val)
    else $error("rslt_val longer than one cycle");

  // one block in flight
  a_one_block: assert property (@(posedge iclk) disable iff (ireset)
    synd_val |-> !in_flight)
    else $error("second synd_val before loc_val");

endmodule

bind bch_eras_dec_top bch_eras_chk i_bch_eras_chk (
  .iclk     (iclk),
  .ireset   (ireset),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .synd_val (synd_val),
  .loc_val  (loc_val),
  .rslt_val (rslt_val)
);

//--- dv/bch_eras_tb.sv
// testbench for the BCH(15,5) erasure decoder, Wishbone bus tasks,
// reference encoder, run limit and directed tests
`timescale 1ns/1ps

module bch_eras_tb
  import bch_pkg::*;
();

  // decodes issued over all tests
  localparam int cNUM_DEC   = 32 + 20 + 12 + 10 + 2;
  localparam int cCYC_LIMIT = 200 * cNUM_DEC;
  // generator x^10+x^8+x^5+x^4+x^2+x+1
  localparam logic [10:0] cGEN = 11'b101_0011_0111;

  logic                   iclk;
  logic                   ireset;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [cWB_ADDR_W-1:0]  wb_adr;
  logic [cWB_DATA_W-1:0]  wb_dat_i;
  logic [cWB_DATA_W-1:0]  wb_dat_o;
  logic                   wb_ack;

  integer seed;
  int     errors;
  int     tests_pass;
  int     tests_fail;
  int     test_err0;
  int     cycles = 0;

  bch_eras_dec_top i_bch_eras_dec_top (
    .iclk     (iclk),
    .ireset   (ireset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;
  end

  // run limit
  always @(posedge iclk) begin
    cycles = cycles + 1;
    if (cycles >= cCYC_LIMIT) begin
      $display("timeout: no finish after %0d cycles, a decode or bus cycle hung", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // bus tasks, ack sampled at the rising edge
  // --------------------------------------------------------------------------
  task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
    @(posedge iclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= dat;
    @(posedge iclk);
    // start writes stall here while a block is busy
    while (!wb_ack) @(posedge iclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
    @(posedge iclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    @(posedge iclk);
    while (!wb_ack) @(posedge iclk);
    dat = wb_dat_o;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  // data polynomial times generator over GF(2)
  function automatic word_t encode(logic [4:0] d);
    word_t cw;
    cw = '0;
    for (int i = 0; i < 5; i++) begin
      if (d[i]) cw = cw ^ (word_t'(cGEN) << i);
    end
    return cw;
  endfunction

  // k distinct random positions outside avoid
  task automatic rand_positions(input int k, input word_t avoid, output word_t m);
    int p;
    m = '0;
    while ($countones(m) < k) begin
      p = int'($unsigned($random(seed)) % cN);
      if (!avoid[p]) m[p] = 1'b1;
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic close_test(input string name);
    if (errors == test_err0) begin
      tests_pass++;
      $display("%s: pass", name);
    end else begin
      tests_fail++;
      $display("%s: FAIL with %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  task automatic wait_done(output logic [31:0] st);
    wb_read(2'd2, st);
    while (!st[0]) wb_read(2'd2, st);
  endtask

  // status: done 0, fail 1, tag 3:2, count 6:4
  task automatic check_result(input string what, input logic [31:0] st,
                              input logic [31:0] wd, input word_t exp_word,
                              input tag_t exp_tag, input int exp_cnt);
    if (wd[cN-1:0] !== exp_word) report_mismatch({what, " word"}, wd, {17'd0, exp_word});
    if (st[1] !== 1'b0) report_mismatch({what, " fail bit"}, st, 32'd0);
    if (st[3:2] !== exp_tag) report_mismatch({what, " tag"}, st, {30'd0, exp_tag});
    if (st[6:4] !== 3'(exp_cnt)) report_mismatch({what, " count"}, st, 32'(exp_cnt));
  endtask

  task automatic decode_check(input string what, input word_t rx, input word_t mask,
                              input tag_t tg, input word_t exp_word, input int exp_cnt);
    logic [31:0] st;
    logic [31:0] wd;
    wb_write(2'd0, {17'd0, rx});
    wb_write(2'd1, {1'b1, 13'd0, tg, 1'b0, mask});
    wait_done(st);
    wb_read(2'd3, wd);
    check_result(what, st, wd, exp_word, tg, exp_cnt);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic reset_and_regs();
    logic [31:0] rd;
    wb_read(2'd2, rd);
    if (rd[1:0] !== 2'b00) report_mismatch("status after reset", rd, 32'd0);
    wb_write(2'd0, 32'h0000_5a3c);
    wb_read(2'd0, rd);
    if (rd !== 32'h0000_5a3c) report_mismatch("word readback", rd, 32'h0000_5a3c);
    // tag 2, mask only, start bit clear
    wb_write(2'd1, 32'h0002_6c91);
    wb_read(2'd1, rd);
    if (rd !== 32'h0002_6c91) report_mismatch("mask readback", rd, 32'h0002_6c91);
    close_test("reset_and_regs");
  endtask

  task automatic clean_words();
    word_t cw;
    for (int d = 0; d < 32; d++) begin
      cw = encode(5'(d));
      decode_check("clean", cw, '0, tag_t'(d), cw, 0);
    end
    close_test("clean_words");
  endtask

  task automatic errors_only();
    word_t cw;
    word_t em;
    int    e;
    for (int i = 0; i < 20; i++) begin
      e  = 1 + i % 3;
      cw = encode(5'($random(seed)));
      rand_positions(e, '0, em);
      decode_check("errors", cw ^ em, '0, tag_t'(i), cw, e);
    end
    close_test("errors_only");
  endtask

  task automatic erasures_only();
    word_t       cw;
    word_t       em;
    word_t       junk;
    logic [4:0]  d;
    int          f;
    int          a;
    for (int i = 0; i < 12; i++) begin
      f = 1 + i % 6;
      d = 5'($random(seed));
      if (d == 5'd0) d = 5'd1;
      cw = encode(d);
      // odd cases erase only ones, so the one fill is already exact
      if (i % 2 == 1) rand_positions(f, ~cw, em);
      else rand_positions(f, '0, em);
      junk = word_t'($random(seed));
      // zero fill is wrong wherever an erased bit was a one
      a = $countones(cw & em);
      decode_check("erasures", (cw & ~em) | (junk & em), em, tag_t'(i), cw,
                   (a <= f - a) ? a : f - a);
    end
    close_test("erasures_only");
  endtask

  task automatic mixed_damage();
    word_t cw;
    word_t em;
    word_t errm;
    word_t junk;
    int    e;
    int    f;
    int    a;
    for (int i = 0; i < 10; i++) begin
      // (1,1) (1,2) (1,3) (1,4) (2,1) (2,2)
      e  = (i % 6 < 4) ? 1 : 2;
      f  = (i % 6 < 4) ? 1 + i % 6 : i % 6 - 3;
      cw = encode(5'($random(seed)));
      rand_positions(f, '0, em);
      rand_positions(e, em, errm);
      junk = word_t'($random(seed));
      a = $countones(cw & em);
      decode_check("mixed", ((cw & ~em) | (junk & em)) ^ errm, em, tag_t'(i), cw,
                   e + ((a <= f - a) ? a : f - a));
    end
    close_test("mixed_damage");
  endtask

  task automatic backpressure();
    logic [31:0] st;
    logic [31:0] wd;
    word_t       cw_a;
    word_t       cw_b;
    cw_a = encode(5'h13);
    cw_b = encode(5'h0a);
    // block a, errors at 0 and 9, tag 3
    wb_write(2'd0, {17'd0, cw_a ^ 15'h0201});
    wb_write(2'd1, {1'b1, 13'd0, 2'd3, 1'b0, 15'd0});
    // block b word goes in while a runs
    wb_write(2'd0, {17'd0, cw_b ^ 15'h4000});
    wb_write(2'd1, {1'b1, 13'd0, 2'd2, 1'b0, 15'd0});
    // b just started, result registers still hold a
    wb_read(2'd2, st);
    wb_read(2'd3, wd);
    if (st[0] !== 1'b0) report_mismatch("second start done bit", st, 32'd0);
    check_result("backpressure first", st, wd, cw_a, 2'd3, 2);
    wait_done(st);
    wb_read(2'd3, wd);
    check_result("backpressure second", st, wd, cw_b, 2'd2, 1);
    close_test("backpressure");
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    seed       = 32'h8183;
    errors     = 0;
    tests_pass = 0;
    tests_fail = 0;
    test_err0  = 0;
    ireset     = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_i   = '0;
    repeat (2) @(posedge iclk);
    ireset <= 1'b0;

    reset_and_regs();
    clean_words();
    errors_only();
    erasures_only();
    mixed_damage();
    backpressure();

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_pass, tests_fail, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- bch_eras.f
hw/bch_pkg.sv
hw/bch_wb_regs.sv
hw/bch_eras_syndrome.sv
hw/bch_eras_berlekamp_ribm_t_by_t.sv
hw/bch_eras_chien.sv
hw/bch_eras_dec_top.sv
dv/bch_eras_chk.sv
dv/bch_eras_tb.sv

//--- Makefile
# Verilator build and run for the BCH(15,5) erasure decoder testbench

VERILATOR ?= verilator
TOP       ?= bch_eras_tb
FILELIST  ?= bch_eras.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# binary is rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

check:
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
